// ==== src/aluPkg.sv ====
// aluPkg: shared widths, opcodes, lane sizes and request/result types for the execution unit
package aluPkg;

	// ================================================
	// widths and iteration counts
	// ================================================
	localparam int dataWidth = 64;
	localparam int mulDivSteps = 64;

	// step counter covers the iterations, the sign fix and the final latch
	localparam int cntWidth = $clog2(mulDivSteps + 2);
	localparam logic [cntWidth-1:0] fixStep = cntWidth'(mulDivSteps);
	localparam logic [cntWidth-1:0] lastStep = cntWidth'(mulDivSteps + 1);

	// lowest bit of every lane, per lane size
	localparam logic [dataWidth-1:0] lsbMask8 = 64'h0101_0101_0101_0101;
	localparam logic [dataWidth-1:0] lsbMask16 = 64'h0001_0001_0001_0001;
	localparam logic [dataWidth-1:0] lsbMask32 = 64'h0000_0001_0000_0001;
	localparam logic [dataWidth-1:0] lsbMask64 = 64'h0000_0000_0000_0001;

	// ================================================
	// encodings
	// ================================================
	// 18 operations need five bits
	typedef enum logic [4:0]
	{
		opAdd, opSub, opAnd, opOr, opXor,
		opSeq, opSlt, opSltu, opMin, opMax,
		opMul, opMulu, opMulh, opMuluh,
		opDiv, opDivu, opMod, opModu
	} aluOp;

	typedef enum logic [1:0]
	{
		lane8 = 2'd0,
		lane16 = 2'd1,
		lane32 = 2'd2,
		lane64 = 2'd3
	} laneSize;

	typedef enum logic [1:0]
	{
		excNone = 2'd0,
		excOverflow = 2'd1,
		excDivZero = 2'd2
	} excCode;

	// ================================================
	// structs
	// ================================================
	typedef struct packed
	{
		logic addSub;
		logic mul;
		logic div;
	} excEnable;

	typedef struct packed
	{
		aluOp op;
		laneSize size;
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
	} aluReq;

	typedef struct packed
	{
		logic [dataWidth-1:0] value;
		logic ovf;
	} laneResult;

	typedef struct packed
	{
		logic [dataWidth-1:0] value;
		logic active;
		logic ovf;
		logic divZero;
	} mulDivResult;

endpackage

// ==== src/laneAlu.sv ====
// laneAlu: combinational add, subtract, logic, compare and min/max on 8 to 64-bit lanes
`timescale 1ns/1ps

module laneAlu
(
	input aluPkg::aluReq req,
	output aluPkg::laneResult res
);

	// lane boundary masks
	logic [aluPkg::dataWidth-1:0] lsb;
	logic [aluPkg::dataWidth-1:0] msb;
	logic [6:0] msbPos;

	logic [aluPkg::dataWidth-1:0] opA;
	logic [aluPkg::dataWidth-1:0] opB;
	logic [aluPkg::dataWidth-1:0] invB;
	logic [aluPkg::dataWidth-1:0] diffBits;

	logic [aluPkg::dataWidth-1:0] sum;
	logic [aluPkg::dataWidth-1:0] diff;
	logic [aluPkg::dataWidth-1:0] nonZeroH;
	logic [aluPkg::dataWidth-1:0] eqH;
	logic [aluPkg::dataWidth-1:0] ltH;
	logic [aluPkg::dataWidth-1:0] ltuH;
	logic [aluPkg::dataWidth-1:0] ltFill;
	logic [aluPkg::dataWidth-1:0] minVal;
	logic [aluPkg::dataWidth-1:0] maxVal;

	logic wide;
	logic addOvf;
	logic subOvf;

	// ================================================
	// lane masks
	// ================================================
	always_comb
	begin
		case (req.size)
			aluPkg::lane8: lsb = aluPkg::lsbMask8;
			aluPkg::lane16: lsb = aluPkg::lsbMask16;
			aluPkg::lane32: lsb = aluPkg::lsbMask32;
			default: lsb = aluPkg::lsbMask64;
		endcase
	end

	// lane width minus one, 7 to 63
	assign msbPos = (7'd8 << req.size) - 7'd1;
	assign msb = lsb << msbPos;
	assign wide = (req.size == aluPkg::lane64);

	assign opA = req.a;
	assign opB = req.b;
	assign invB = ~req.b;
	assign diffBits = req.a ^ req.b;

	// ================================================
	// lane arithmetic
	// ================================================
	// add the low bits of each lane, then fold the msb in separately
	// so no carry crosses a lane boundary
	assign sum = ((opA & ~msb) + (opB & ~msb)) ^ (diffBits & msb);
	// a + ~b + 1 in every lane
	assign diff = ((opA & ~msb) + (invB & ~msb) + lsb) ^ ((opA ^ invB) & msb);

	// borrow out of each lane's msb, with and without sign correction
	assign ltuH = ((~opA & opB) | (~diffBits & diff)) & msb;
	assign ltH = ((opA & ~opB) | (~diffBits & diff)) & msb;

	// low bits of a nonzero lane carry into its msb
	assign nonZeroH = ((((diffBits & ~msb) + ~msb) | diffBits) & msb);
	assign eqH = ~nonZeroH & msb;

	// spread the signed less-than flag over its whole lane
	assign ltFill = (ltH - (ltH >> msbPos)) | ltH;
	assign minVal = (opA & ltFill) | (opB & ~ltFill);
	assign maxVal = (opB & ltFill) | (opA & ~ltFill);

	// signed overflow is reported for the full-width lane only
	assign addOvf = (opA[63] == opB[63]) && (sum[63] != opA[63]);
	assign subOvf = (opA[63] != opB[63]) && (diff[63] != opA[63]);

	// ================================================
	// result select
	// ================================================
	always_comb
	begin
		res.value = '0;
		res.ovf = 1'b0;
		case (req.op)
			aluPkg::opAdd:
			begin
				res.value = sum;
				res.ovf = wide & addOvf;
			end
			aluPkg::opSub:
			begin
				res.value = diff;
				res.ovf = wide & subOvf;
			end
			aluPkg::opAnd: res.value = opA & opB;
			aluPkg::opOr: res.value = opA | opB;
			aluPkg::opXor: res.value = diffBits;
			// compare flags move down to the lowest bit of the lane
			aluPkg::opSeq: res.value = eqH >> msbPos;
			aluPkg::opSlt: res.value = ltH >> msbPos;
			aluPkg::opSltu: res.value = ltuH >> msbPos;
			aluPkg::opMin: res.value = minVal;
			aluPkg::opMax: res.value = maxVal;
			default: res.value = '0;
		endcase
	end

endmodule

// ==== src/mulDivUnit.sv ====
// mulDivUnit: iterative shift-add multiplier and restoring divider with done and abort
`timescale 1ns/1ps

module mulDivUnit
(
	input logic clk,
	input logic rst,
	input logic ld,
	input logic abort,
	input aluPkg::aluReq req,
	output aluPkg::mulDivResult res,
	output logic done
);

	// control
	logic busy;
	logic [aluPkg::cntWidth-1:0] cnt;
	logic mdOp;
	logic startOp;

	// datapath: acc holds {high, low} of the product or {remainder, quotient}
	aluPkg::aluOp opReg;
	logic [2*aluPkg::dataWidth-1:0] acc;
	logic [aluPkg::dataWidth-1:0] operand;
	logic negLow;
	logic negHigh;
	logic divisorZero;

	logic signA;
	logic signB;
	logic [aluPkg::dataWidth-1:0] magA;
	logic [aluPkg::dataWidth-1:0] magB;
	logic [aluPkg::dataWidth:0] addStep;
	logic [aluPkg::dataWidth:0] subStep;
	logic [aluPkg::dataWidth-1:0] hiWord;
	logic [aluPkg::dataWidth-1:0] loWord;
	logic [aluPkg::dataWidth-1:0] quoFix;
	logic [aluPkg::dataWidth-1:0] remFix;
	logic [2*aluPkg::dataWidth-1:0] prodFix;
	logic mulOvf;

	// held result
	logic [aluPkg::dataWidth-1:0] valueReg;
	logic ovfReg;
	logic divZeroReg;

	function automatic logic isMulOp(input aluPkg::aluOp op);
		return op inside {aluPkg::opMul, aluPkg::opMulu, aluPkg::opMulh, aluPkg::opMuluh};
	endfunction

	function automatic logic isDivOp(input aluPkg::aluOp op);
		return op inside {aluPkg::opDiv, aluPkg::opDivu, aluPkg::opMod, aluPkg::opModu};
	endfunction

	function automatic logic isSignedOp(input aluPkg::aluOp op);
		return op inside {aluPkg::opMul, aluPkg::opMulh, aluPkg::opDiv, aluPkg::opMod};
	endfunction

	// ops that deliver the upper half of acc
	function automatic logic isHighOp(input aluPkg::aluOp op);
		return op inside {aluPkg::opMulh, aluPkg::opMuluh, aluPkg::opMod, aluPkg::opModu};
	endfunction

	assign mdOp = isMulOp(req.op) | isDivOp(req.op);
	assign startOp = ld & mdOp;

	// operands enter as magnitudes, sign is restored in the fix step
	assign signA = isSignedOp(req.op) & req.a[aluPkg::dataWidth-1];
	assign signB = isSignedOp(req.op) & req.b[aluPkg::dataWidth-1];
	assign magA = signA ? -req.a : req.a;
	assign magB = signB ? -req.b : req.b;

	assign hiWord = acc[2*aluPkg::dataWidth-1:aluPkg::dataWidth];
	assign loWord = acc[aluPkg::dataWidth-1:0];

	// one multiply step adds the multiplicand when the low bit is set
	assign addStep = {1'b0, hiWord} + (acc[0] ? {1'b0, operand} : '0);
	// one divide step tries the divisor against the shifted remainder
	assign subStep = acc[2*aluPkg::dataWidth-1:aluPkg::dataWidth-1] - {1'b0, operand};

	assign prodFix = negLow ? -acc : acc;
	assign quoFix = divisorZero ? '1 : (negLow ? -loWord : loWord);
	assign remFix = negHigh ? -hiWord : hiWord;

	assign mulOvf = isSignedOp(opReg) ? (hiWord != {aluPkg::dataWidth{loWord[63]}})
		: (hiWord != '0);

	// ================================================
	// control
	// ================================================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			done <= 1'b1;
			cnt <= '0;
			valueReg <= '0;
			ovfReg <= 1'b0;
			divZeroReg <= 1'b0;
		end
		else if (abort)
		begin
			busy <= 1'b0;
			done <= 1'b1;
		end
		else if (startOp)
		begin
			busy <= 1'b1;
			done <= 1'b0;
			cnt <= '0;
		end
		else if (busy)
		begin
			cnt <= cnt + 1'b1;
			if (cnt == aluPkg::lastStep)
			begin
				busy <= 1'b0;
				done <= 1'b1;
				valueReg <= isHighOp(opReg) ? hiWord : loWord;
				ovfReg <= isMulOp(opReg) & mulOvf;
				divZeroReg <= isDivOp(opReg) & divisorZero;
			end
		end
	end

	// ================================================
	// datapath
	// ================================================
	always_ff @(posedge clk)
	begin
		if (startOp)
		begin
			opReg <= req.op;
			operand <= magB;
			negLow <= signA ^ signB;
			negHigh <= signA;
			divisorZero <= (req.b == '0);
			acc <= {{aluPkg::dataWidth{1'b0}}, magA};
		end
		else if (busy)
		begin
			if (cnt < aluPkg::fixStep)
			begin
				if (isDivOp(opReg))
					acc <= subStep[aluPkg::dataWidth] ? {acc[2*aluPkg::dataWidth-2:0], 1'b0}
						: {subStep[aluPkg::dataWidth-1:0], acc[aluPkg::dataWidth-2:0], 1'b1};
				else
					acc <= {addStep, acc[aluPkg::dataWidth-1:1]};
			end
			else if (cnt == aluPkg::fixStep)
				acc <= isDivOp(opReg) ? {remFix, quoFix} : prodFix;
		end
	end

	assign res = '{value: valueReg, active: mdOp, ovf: ovfReg, divZero: divZeroReg};

endmodule

// ==== src/resultMerge.sv ====
// resultMerge: selects the active unit's result and encodes the enabled exception
`timescale 1ns/1ps

module resultMerge
(
	input aluPkg::laneResult lane,
	input aluPkg::mulDivResult md,
	input aluPkg::excEnable excen,
	output logic [aluPkg::dataWidth-1:0] result,
	output aluPkg::excCode exc
);

	logic laneOvf;
	logic mulOvf;
	logic divFault;

	// ================================================
	// result
	// ================================================
	// the multiply/divide engine owns the output while its op is held
	assign result = md.active ? md.value : lane.value;

	// ================================================
	// exceptions
	// ================================================
	// each source is masked by its own enable bit
	assign laneOvf = ~md.active & lane.ovf & excen.addSub;
	assign mulOvf = md.active & md.ovf & excen.mul;
	assign divFault = md.active & md.divZero & excen.div;

	always_comb
	begin
		if (divFault)
			exc = aluPkg::excDivZero;
		else if (laneOvf | mulOvf)
			exc = aluPkg::excOverflow;
		else
			exc = aluPkg::excNone;
	end

endmodule

// ==== src/execUnit.sv ====
// execUnit: 64-bit integer execution unit joining the lane ALU and the multiply/divide engine
`timescale 1ns/1ps

module execUnit
(
	input logic clk,
	input logic rst,
	input logic ld,
	input logic abort,
	input aluPkg::aluOp op,
	input aluPkg::laneSize size,
	input logic [aluPkg::dataWidth-1:0] a,
	input logic [aluPkg::dataWidth-1:0] b,
	input aluPkg::excEnable excen,
	output logic [aluPkg::dataWidth-1:0] result,
	output logic done,
	output aluPkg::excCode exc
);

	aluPkg::aluReq req;
	aluPkg::laneResult laneRes;
	aluPkg::mulDivResult mdRes;

	assign req = '{op: op, size: size, a: a, b: b};

	// both units see the same request and work side by side
	laneAlu laneAlu_i
	(
		.req(req),
		.res(laneRes)
	);

	mulDivUnit mulDivUnit_i
	(
		.clk(clk),
		.rst(rst),
		.ld(ld),
		.abort(abort),
		.req(req),
		.res(mdRes),
		.done(done)
	);

	resultMerge resultMerge_i
	(
		.lane(laneRes),
		.md(mdRes),
		.excen(excen),
		.result(result),
		.exc(exc)
	);

endmodule

// ==== bench/execUnitTb.sv ====
// testbench for the execution unit with random and directed stimulus and a reference model
`timescale 1ns/1ps

module execUnitTb;

	localparam int period = 40;
	localparam int mdSteps = 64;
	localparam int laneCount = 300;
	localparam int mdCount = 40;
	// directed lane cases plus the abort sequence
	localparam int extraCount = 8;
	localparam int watchdogTime = (laneCount + mdCount + extraCount) * (mdSteps + 10) * period;

	logic clk;
	logic rst;
	logic ld;
	logic abort;
	aluPkg::aluOp op;
	aluPkg::laneSize size;
	logic [63:0] a;
	logic [63:0] b;
	aluPkg::excEnable excen;
	logic [63:0] result;
	logic done;
	aluPkg::excCode exc;

	int mismatchCount;
	int failCount;
	logic [31:0] seed;

	int i;
	logic [31:0] r;
	aluPkg::aluOp o;
	logic [63:0] x;
	logic [63:0] y;

	execUnit execUnit_i
	(
		.clk(clk),
		.rst(rst),
		.ld(ld),
		.abort(abort),
		.op(op),
		.size(size),
		.a(a),
		.b(b),
		.excen(excen),
		.result(result),
		.done(done),
		.exc(exc)
	);

	always #(period / 2) clk = ~clk;

	// ==================================================
	// random numbers and reference model
	// ==================================================
	function automatic logic [31:0] lcgNext();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [63:0] rand64();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = lcgNext();
		lo = lcgNext();
		return {hi, lo};
	endfunction

	// each lane on its own and compares leave 0 or 1 in the lane
	function automatic logic [63:0] laneModel(input aluPkg::aluOp fn, input aluPkg::laneSize sz,
		input logic [63:0] va, input logic [63:0] vb);
		int w;
		int k;
		logic [63:0] mask;
		logic [63:0] sb;
		logic [63:0] la;
		logic [63:0] lb;
		logic [63:0] lr;
		logic [63:0] acc;
		w = 8 << int'(sz);
		mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
		sb = 64'd1 << (w - 1);
		acc = '0;
		for (k = 0; k < 64 / w; k++)
		begin
			la = (va >> (k * w)) & mask;
			lb = (vb >> (k * w)) & mask;
			case (fn)
				aluPkg::opAdd: lr = (la + lb) & mask;
				aluPkg::opSub: lr = (la - lb) & mask;
				aluPkg::opAnd: lr = la & lb;
				aluPkg::opOr: lr = la | lb;
				aluPkg::opXor: lr = la ^ lb;
				aluPkg::opSeq: lr = {63'd0, la == lb};
				aluPkg::opSlt: lr = {63'd0, (la ^ sb) < (lb ^ sb)};
				aluPkg::opSltu: lr = {63'd0, la < lb};
				aluPkg::opMin: lr = ((la ^ sb) < (lb ^ sb)) ? la : lb;
				aluPkg::opMax: lr = ((la ^ sb) < (lb ^ sb)) ? lb : la;
				default: lr = '0;
			endcase
			acc = acc | (lr << (k * w));
		end
		return acc;
	endfunction

	function automatic void mdModel(input aluPkg::aluOp fn, input logic [63:0] va,
		input logic [63:0] vb, output logic [63:0] value, output logic ovf, output logic dz);
		logic sgn;
		logic negA;
		logic negB;
		logic [127:0] prod;
		logic [63:0] magA;
		logic [63:0] magB;
		logic [63:0] q;
		logic [63:0] rm;
		sgn = fn inside {aluPkg::opMul, aluPkg::opMulh, aluPkg::opDiv, aluPkg::opMod};
		ovf = 1'b0;
		dz = 1'b0;
		if (fn inside {aluPkg::opMul, aluPkg::opMulu, aluPkg::opMulh, aluPkg::opMuluh})
		begin
			prod = sgn ? {{64{va[63]}}, va} * {{64{vb[63]}}, vb} : {64'd0, va} * {64'd0, vb};
			value = (fn inside {aluPkg::opMulh, aluPkg::opMuluh}) ? prod[127:64] : prod[63:0];
			ovf = sgn ? (prod[127:64] != {64{prod[63]}}) : (prod[127:64] != 64'd0);
		end
		else
		begin
			negA = sgn & va[63];
			negB = sgn & vb[63];
			magA = negA ? -va : va;
			magB = negB ? -vb : vb;
			if (vb == 64'd0)
			begin
				dz = 1'b1;
				q = '1;
				rm = va;
			end
			else
			begin
				// truncate toward zero and let the remainder follow the dividend
				q = magA / magB;
				rm = magA % magB;
				q = (negA ^ negB) ? -q : q;
				rm = negA ? -rm : rm;
			end
			value = (fn inside {aluPkg::opMod, aluPkg::opModu}) ? rm : q;
		end
	endfunction

	// ==================================================
	// drivers that start and end on a falling edge
	// ==================================================
	task automatic runLane(input aluPkg::aluOp fn, input aluPkg::laneSize sz,
		input logic [63:0] va, input logic [63:0] vb, input aluPkg::excEnable en);
		logic [63:0] expValue;
		logic [64:0] wideRes;
		logic ovfRule;
		aluPkg::excCode expExc;
		expValue = laneModel(fn, sz, va, vb);
		ovfRule = 1'b0;
		// the sign-extended result leaves the 64-bit range on overflow
		if (sz == aluPkg::lane64 && fn == aluPkg::opAdd)
		begin
			wideRes = {va[63], va} + {vb[63], vb};
			ovfRule = wideRes[64] != wideRes[63];
		end
		if (sz == aluPkg::lane64 && fn == aluPkg::opSub)
		begin
			wideRes = {va[63], va} - {vb[63], vb};
			ovfRule = wideRes[64] != wideRes[63];
		end
		expExc = (ovfRule && en.addSub) ? aluPkg::excOverflow : aluPkg::excNone;
		op = fn;
		size = sz;
		a = va;
		b = vb;
		excen = en;
		@(negedge clk);
		if (result !== expValue)
		begin
			$display("mismatch result: got %h expected %h (%s)", result, expValue, fn.name());
			mismatchCount++;
		end
		if (exc !== expExc)
		begin
			$display("mismatch exc: got %h expected %h (%s)", exc, expExc, fn.name());
			mismatchCount++;
		end
		if (done !== 1'b1)
		begin
			$display("done went low during a lane operation");
			failCount++;
		end
	endtask

	task automatic runMulDiv(input aluPkg::aluOp fn, input logic [63:0] va,
		input logic [63:0] vb, input aluPkg::excEnable en);
		logic [63:0] expValue;
		logic expOvf;
		logic expDz;
		aluPkg::excCode expExc;
		int edges;
		mdModel(fn, va, vb, expValue, expOvf, expDz);
		if (expDz && en.div)
			expExc = aluPkg::excDivZero;
		else if (expOvf && en.mul)
			expExc = aluPkg::excOverflow;
		else
			expExc = aluPkg::excNone;
		op = fn;
		size = aluPkg::lane64;
		a = va;
		b = vb;
		excen = en;
		ld = 1'b1;
		@(negedge clk);
		ld = 1'b0;
		if (done !== 1'b0)
		begin
			$display("done did not go low after ld for %s", fn.name());
			failCount++;
		end
		edges = 0;
		while (done !== 1'b1 && edges < mdSteps + 10)
		begin
			@(negedge clk);
			edges++;
		end
		if (edges != mdSteps + 2)
		begin
			$display("done stayed low for %0d edges, expected %0d", edges - 1, mdSteps + 1);
			failCount++;
		end
		if (result !== expValue)
		begin
			$display("mismatch result: got %h expected %h (%s)", result, expValue, fn.name());
			mismatchCount++;
		end
		if (exc !== expExc)
		begin
			$display("mismatch exc: got %h expected %h (%s)", exc, expExc, fn.name());
			mismatchCount++;
		end
	endtask

	// ==================================================
	// watchdog
	// ==================================================
	initial
	begin
		#(watchdogTime);
		$display("timeout: the run did not finish within %0d ns", watchdogTime);
		$display("Test failures found");
		$finish;
	end

	initial
	begin
		seed = 32'h5f14ba06;
		mismatchCount = 0;
		failCount = 0;
		clk = 1'b0;
		rst = 1'b1;
		ld = 1'b0;
		abort = 1'b0;
		op = aluPkg::opMul;
		size = aluPkg::lane64;
		a = '0;
		b = '0;
		excen = aluPkg::excEnable'(3'b111);
		repeat (2) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		// idle state with the held multiply result cleared
		if (done !== 1'b1)
		begin
			$display("done is not high after reset");
			failCount++;
		end
		if (exc !== aluPkg::excNone)
		begin
			$display("mismatch exc: got %h expected %h after reset", exc, aluPkg::excNone);
			mismatchCount++;
		end
		if (result !== 64'd0)
		begin
			$display("mismatch result: got %h expected %h after reset", result, 64'd0);
			mismatchCount++;
		end

		// signed overflow only counts in the 64-bit lane
		runLane(aluPkg::opAdd, aluPkg::lane64, 64'h7fff_ffff_ffff_ffff, 64'd1,
			aluPkg::excEnable'(3'b100));
		runLane(aluPkg::opAdd, aluPkg::lane64, 64'h7fff_ffff_ffff_ffff, 64'd1,
			aluPkg::excEnable'(3'b011));
		runLane(aluPkg::opSub, aluPkg::lane64, 64'h8000_0000_0000_0000, 64'd1,
			aluPkg::excEnable'(3'b100));
		runLane(aluPkg::opAdd, aluPkg::lane8, 64'h7f7f_7f7f_7f7f_7f7f, 64'h0101_0101_0101_0101,
			aluPkg::excEnable'(3'b111));

		for (i = 0; i < laneCount; i++)
		begin
			r = lcgNext();
			o = aluPkg::aluOp'(5'(r[23:16] % 8'd10));
			x = rand64();
			y = rand64();
			// some lanes equal so compares see both outcomes
			if (r[9:8] == 2'd0)
				y = x ^ (y & 64'h00ff_0000_ff00_00ff);
			runLane(o, aluPkg::laneSize'(r[25:24]), x, y, aluPkg::excEnable'(r[28:26]));
		end

		for (i = 0; i < mdCount; i++)
		begin
			r = lcgNext();
			o = aluPkg::aluOp'(5'(32'd10 + 32'(r[18:16])));
			x = rand64();
			y = rand64();
			case (i % 8)
				1:
				begin
					x = {{32{x[31]}}, x[31:0]};
					y = {{32{y[31]}}, y[31:0]};
				end
				3:
				begin
					y = '0;
					o = r[19] ? aluPkg::opDivu : aluPkg::opMod;
				end
				6:
				begin
					x = 64'h8000_0000_0000_0000;
					y = '1;
					o = r[19] ? aluPkg::opDiv : aluPkg::opMod;
				end
				default:
				begin
				end
			endcase
			runMulDiv(o, x, y, aluPkg::excEnable'(r[22:20]));
		end

		// abort a divide halfway and then run a full one
		op = aluPkg::opDivu;
		a = rand64();
		b = 64'd7;
		ld = 1'b1;
		@(negedge clk);
		ld = 1'b0;
		repeat (20) @(negedge clk);
		if (done !== 1'b0)
		begin
			$display("done is not low while the divide to be aborted runs");
			failCount++;
		end
		abort = 1'b1;
		@(negedge clk);
		abort = 1'b0;
		if (done !== 1'b1)
		begin
			$display("done not high one edge after abort");
			failCount++;
		end
		runMulDiv(aluPkg::opMulh, rand64(), rand64(), aluPkg::excEnable'(3'b111));

		$display("errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
		if (mismatchCount + failCount == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== project.f ====
src/aluPkg.sv
src/laneAlu.sv
src/mulDivUnit.sv
src/resultMerge.sv
src/execUnit.sv
bench/execUnitTb.sv

// ==== Makefile ====
# Verilator build and run for the execution unit testbench

SRCS := $(wildcard src/*.sv bench/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/VexecUnitTb: project.f $(SRCS)
	verilator --binary --top-module execUnitTb -f project.f

# the run passes only when the pass message shows up in the output
run: obj_dir/VexecUnitTb
	@out="$$(./obj_dir/VexecUnitTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
